// File: design/binning_pkg.sv
/*
  shared definitions for the weight binning datapath
  sizes, DRAM layout, bus field types and the two state encodings
*/
package binning_pkg;

	////////////////////////////////////////////////////////////////////
	// sizes and DRAM layout
	////////////////////////////////////////////////////////////////////
	localparam int NUM_BINS = 8;                          // on-chip bins
	localparam int BIN_DEPTH = 4;                         // weights per bin before forced flush
	localparam int BLOCK_LEN = 24;                        // weights per block
	localparam logic [31:0] DRAM_BASE = 32'h1000_0000;    // start of bin area
	localparam logic [31:0] BIN_REGION_BYTES = 32'h400;   // spacing of bin regions
	localparam int BYTES_PER_WORD = 4;

	typedef logic [31:0] weight_t;
	typedef logic [12:0] key_t;         // low bits of a weight, used to pick the bin
	typedef logic [2:0]  bin_idx_t;
	typedef logic [2:0]  fill_t;        // 0 .. BIN_DEPTH
	typedef logic [8:0]  dram_off_t;    // words already written for a bin
	typedef logic [31:0] bus_addr_t;
	typedef logic [19:0] bus_len_t;     // burst length in bytes
	typedef logic [4:0]  blk_cnt_t;

	////////////////////////////////////////////////////////////////////
	// inter-block bundles
	////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic     start;    // one-cycle strobe
		bin_idx_t bin;
	} flush_req_t;

	typedef struct packed {
		logic      req;     // write request level
		bus_addr_t addr;
		bus_len_t  len;
	} mst_cmd_t;

	typedef struct packed {
		weight_t data;
		logic    sof_n;
		logic    eof_n;
		logic    src_rdy_n;
	} mstwr_t;

	typedef struct packed {
		logic cmdack;
		logic cmplt;
		logic dst_rdy_n;
	} bus_resp_t;

	typedef enum logic [2:0] {S_IDLE, S_RECEIVE, S_FLUSH_FULL, S_FLUSH_ALL, S_DONE} seq_state_t;
	typedef enum logic [2:0] {W_IDLE, W_REQUEST, W_WAIT_ACK, W_DATA, W_WAIT_CMPLT} wr_state_t;

endpackage

// File: design/bin_sequencer.sv
/*
  block sequencer of the weight binning path
  takes one block of weights off the stream, sorts each one into a bin
  by key range and orders the full-bin and end-of-block flushes
*/
module bin_sequencer (
	input  logic                                           Clk,
	input  logic                                           rst_n,
	input  logic                                           start,      // opens one block
	input  logic                                           in_valid,
	input  binning_pkg::weight_t                           in_data,
	input  logic [binning_pkg::NUM_BINS-1:0]               full,
	input  binning_pkg::fill_t [binning_pkg::NUM_BINS-1:0] fill,
	input  logic                                           flush_done,
	output logic                                           in_ready,
	output logic [binning_pkg::NUM_BINS-1:0]               push_en,    // one-hot
	output binning_pkg::weight_t                           push_data,
	output binning_pkg::flush_req_t                        flush,
	output logic                                           done
);
	import binning_pkg::*;

	seq_state_t          state;
	blk_cnt_t            cnt;       // weights accepted in this block
	key_t                key;
	bin_idx_t            sel_bin;   // bin of the weight on the stream
	logic                accept;
	logic                pending;   // flush issued, writer still busy
	logic [NUM_BINS-1:0] nonempty;

	// lowest bin whose bit is set in the mask
	function automatic bin_idx_t first_bin(input logic [NUM_BINS-1:0] mask);
		bin_idx_t idx;
		idx = '0;
		for (int i = NUM_BINS - 1; i >= 0; i--) begin
			if (mask[i])
				idx = bin_idx_t'(i);
		end
		return idx;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// stream side and classification
	//////////////////////////////////////////////////////////////////////
	assign in_ready = (state == S_RECEIVE) && !(|full) && (cnt != blk_cnt_t'(BLOCK_LEN));
	assign accept = in_valid && in_ready;
	assign key = in_data[12:0];

	// fine bins near zero, coarse at the top
	always_comb begin
		if (key[12])
			sel_bin = 3'd7;
		else if (key[11])
			sel_bin = 3'd6;
		else if (key[10])
			sel_bin = {2'b10, key[9]};  // bins 4 and 5
		else
			sel_bin = {1'b0, key[9:8]}; // bins 0 to 3
	end

	assign push_en = {NUM_BINS{accept}} & (NUM_BINS'(1) << sel_bin);
	assign push_data = in_data;

	always_comb begin
		for (int b = 0; b < NUM_BINS; b++)
			nonempty[b] = (fill[b] != '0);
	end

	//////////////////////////////////////////////////////////////////////
	// block FSM
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			cnt <= '0;
			pending <= 1'b0;
			flush <= '0;
		end else begin
			flush.start <= 1'b0; // strobe, one cycle only
			case (state)
				S_IDLE: begin
					if (start) begin
						cnt <= '0;
						state <= S_RECEIVE;
					end
				end
				S_RECEIVE: begin
					if (accept)
						cnt <= cnt + 1'b1;
					if (|full)
						state <= S_FLUSH_FULL;   // stall and drain that bin first
					else if (cnt == blk_cnt_t'(BLOCK_LEN))
						state <= S_FLUSH_ALL;
				end
				S_FLUSH_FULL: begin
					if (!pending) begin
						flush.start <= 1'b1;
						flush.bin <= first_bin(full);
						pending <= 1'b1;
					end else if (flush_done) begin
						pending <= 1'b0;
						state <= S_RECEIVE;
					end
				end
				S_FLUSH_ALL: begin
					// flushed bins read empty by flush_done, so the lowest non-empty is next
					if (!pending || flush_done) begin
						if (|nonempty) begin
							flush.start <= 1'b1;
							flush.bin <= first_bin(nonempty);
							pending <= 1'b1;
						end else begin
							pending <= 1'b0;
							state <= S_DONE;
						end
					end
				end
				S_DONE: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	assign done = (state == S_DONE);

endmodule

// File: design/bin_buffer.sv
/*
  one weight bin: a small FIFO with its fill count
  plus the count of words this bin has already sent to DRAM
*/
module bin_buffer (
	input  logic                   Clk,
	input  logic                   rst_n,
	input  logic                   clear,      // new block
	input  logic                   push,
	input  binning_pkg::weight_t   push_data,
	input  logic                   drain,      // this bin is being flushed
	input  logic                   pop,
	output binning_pkg::weight_t   head,
	output binning_pkg::fill_t     fill,
	output logic                   full,
	output binning_pkg::dram_off_t dram_off
);
	import binning_pkg::*;

	weight_t                      mem [BIN_DEPTH];
	logic [$clog2(BIN_DEPTH)-1:0] wr_ptr;
	logic [$clog2(BIN_DEPTH)-1:0] rd_ptr;
	logic                         do_pop;

	assign do_pop = drain && pop;   // pop strobe is shared by all bins

	always_ff @(posedge Clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			dram_off <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
			dram_off <= '0;     // each block starts at the bottom of the region
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
				dram_off <= dram_off + 1'b1;
			end
			case ({push, do_pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: ;        // both or neither, count unchanged
			endcase
		end
	end

	assign head = mem[rd_ptr];
	assign full = (fill == fill_t'(BIN_DEPTH));

	// the sequencer must stall the stream before a fifth weight reaches a bin
	a_no_push_full: assert property (@(posedge Clk) disable iff (!rst_n) push |-> !full);

endmodule

// File: design/burst_writer.sv
/*
  write master for bin flushes
  turns one flush request into a command, a framed data burst
  and a completion handshake on the DRAM bus
*/
module burst_writer (
	input  logic                                               Clk,
	input  logic                                               rst_n,
	input  binning_pkg::flush_req_t                            flush,
	input  binning_pkg::weight_t [binning_pkg::NUM_BINS-1:0]   head,
	input  binning_pkg::fill_t [binning_pkg::NUM_BINS-1:0]     fill,
	input  binning_pkg::dram_off_t [binning_pkg::NUM_BINS-1:0] dram_off,
	input  binning_pkg::bus_resp_t                             resp,
	output logic [binning_pkg::NUM_BINS-1:0]                   drain_sel,
	output logic                                               pop,
	output logic                                               flush_done,
	output binning_pkg::mst_cmd_t                              cmd,
	output binning_pkg::mstwr_t                                wr
);
	import binning_pkg::*;

	wr_state_t state;
	bin_idx_t  bin_q;      // bin being flushed
	fill_t     beats_q;    // burst length in words
	fill_t     beat_cnt;   // beats already transferred
	bus_addr_t addr_q;
	bus_len_t  len_q;
	logic      xfer;       // beat moves this edge
	logic      last_beat;

	assign xfer = (state == W_DATA) && !resp.dst_rdy_n;
	assign last_beat = (beat_cnt == beats_q - 1'b1);

	//////////////////////////////////////////////////////////////////////
	// command fields, latched when the flush starts
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge Clk) begin
		if (state == W_IDLE && flush.start) begin
			bin_q <= flush.bin;
			beats_q <= fill[flush.bin];
			addr_q <= bus_addr_t'(DRAM_BASE + flush.bin * BIN_REGION_BYTES
				+ dram_off[flush.bin] * BYTES_PER_WORD);
			len_q <= bus_len_t'(fill[flush.bin] * BYTES_PER_WORD);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// write master FSM
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge Clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= W_IDLE;
			beat_cnt <= '0;
			flush_done <= 1'b0;
		end else begin
			flush_done <= 1'b0;
			case (state)
				W_IDLE: begin
					if (flush.start) begin
						beat_cnt <= '0;
						state <= W_REQUEST;
					end
				end
				W_REQUEST: state <= resp.cmdack ? W_DATA : W_WAIT_ACK; // first request cycle
				W_WAIT_ACK: begin
					if (resp.cmdack)
						state <= W_DATA;
				end
				W_DATA: begin
					if (xfer) begin
						if (last_beat)
							state <= W_WAIT_CMPLT;
						else
							beat_cnt <= beat_cnt + 1'b1;
					end
				end
				W_WAIT_CMPLT: begin
					if (resp.cmplt) begin
						flush_done <= 1'b1;
						state <= W_IDLE;
					end
				end
				default: state <= W_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// bus and bin side outputs
	//////////////////////////////////////////////////////////////////////
	assign cmd.req = (state == W_REQUEST) || (state == W_WAIT_ACK);
	assign cmd.addr = addr_q;
	assign cmd.len = len_q;

	assign wr.data = head[bin_q];                                   // head moves after each pop
	assign wr.src_rdy_n = (state != W_DATA);
	assign wr.sof_n = !((state == W_DATA) && (beat_cnt == '0));
	assign wr.eof_n = !((state == W_DATA) && last_beat);

	assign drain_sel = (state == W_IDLE) ? '0 : (NUM_BINS'(1) << bin_q);
	assign pop = xfer;

	// request is held until the bus acknowledges it
	a_req_held: assert property (@(posedge Clk) disable iff (!rst_n)
		cmd.req && !resp.cmdack |=> cmd.req);

	// sequencer only issues a flush once the previous one has completed
	a_start_idle: assert property (@(posedge Clk) disable iff (!rst_n)
		flush.start |-> state == W_IDLE);

endmodule

// File: design/weight_binning_top.sv
/*
  weight binning top level
  sequencer, one FIFO per bin and the DRAM write master
*/
module weight_binning_top (
	input  logic                   Clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  logic                   in_valid,
	input  binning_pkg::weight_t   in_data,
	input  binning_pkg::bus_resp_t resp,
	output logic                   in_ready,
	output logic                   done,
	output binning_pkg::mst_cmd_t  cmd,
	output binning_pkg::mstwr_t    wr
);
	import binning_pkg::*;

	logic [NUM_BINS-1:0]        push_en;
	weight_t                    push_data;
	logic [NUM_BINS-1:0]        full;
	fill_t [NUM_BINS-1:0]       fill;
	weight_t [NUM_BINS-1:0]     head;
	dram_off_t [NUM_BINS-1:0]   dram_off;
	flush_req_t                 flush;
	logic                       flush_done;
	logic [NUM_BINS-1:0]        drain_sel;
	logic                       pop;

	bin_sequencer u_seq (
		.Clk        (Clk),
		.rst_n      (rst_n),
		.start      (start),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.full       (full),
		.fill       (fill),
		.flush_done (flush_done),
		.in_ready   (in_ready),
		.push_en    (push_en),
		.push_data  (push_data),
		.flush      (flush),
		.done       (done)
	);

	for (genvar b = 0; b < NUM_BINS; b++) begin : g_bin
		bin_buffer u_bin (
			.Clk       (Clk),
			.rst_n     (rst_n),
			.clear     (start),        // start of block empties every bin
			.push      (push_en[b]),
			.push_data (push_data),
			.drain     (drain_sel[b]),
			.pop       (pop),
			.head      (head[b]),
			.fill      (fill[b]),
			.full      (full[b]),
			.dram_off  (dram_off[b])
		);
	end

	burst_writer u_wr (
		.Clk        (Clk),
		.rst_n      (rst_n),
		.flush      (flush),
		.head       (head),
		.fill       (fill),
		.dram_off   (dram_off),
		.resp       (resp),
		.drain_sel  (drain_sel),
		.pop        (pop),
		.flush_done (flush_done),
		.cmd        (cmd),
		.wr         (wr)
	);

endmodule

// File: tests/dram_write_monitor.sv
/*
  DRAM write checker for the weight binning DUT
  rebuilds the bins from the accepted weights and compares every burst
*/
module dram_write_monitor (
	input  logic                   Clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  logic                   in_valid,
	input  logic                   in_ready,
	input  binning_pkg::weight_t   in_data,
	input  logic                   done,
	input  binning_pkg::mst_cmd_t  cmd,
	input  binning_pkg::mstwr_t    wr,
	input  binning_pkg::bus_resp_t resp,
	input  int                     exp_bursts,  // flushes due in this block
	output int                     tests,
	output int                     errors
);
	import binning_pkg::*;

	weight_t model [NUM_BINS][$];   // weights waiting in each bin
	int      offs [NUM_BINS];       // words written per bin this block
	int      accepted;
	int      bursts;
	int      blocks;
	int      cur_bin;
	int      beat;
	int      burst_len;
	logic    busy = 1'b0;           // between request and completion
	logic    prev_req = 1'b0;
	logic    bad = 1'b0;
	logic    reset_bad = 1'b0;
	logic    reset_seen = 1'b0;
	logic    block_open = 1'b0;

	// bin of a key by the non-uniform range rule
	function automatic int bin_of(input key_t k);
		if (k[12])
			return 7;
		if (k[12:11] == 2'b01)
			return 6;
		if (k[12:10] == 3'b001)
			return 4 + k[9];
		return k[9:8];
	endfunction

	// a full bin goes first, then the lowest non-empty one once the block is in
	function automatic int due_bin();
		for (int b = 0; b < NUM_BINS; b++)
			if (model[b].size() == BIN_DEPTH)
				return b;
		if (accepted == BLOCK_LEN)
			for (int b = 0; b < NUM_BINS; b++)
				if (model[b].size() != 0)
					return b;
		return -1;
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("error at %0t: %s is %h, expected %h", $time, name, got, want);
			errors++;
			bad = 1'b1;
		end
	endtask

	task automatic complain(input string what);
		$display("error at %0t: %s", $time, what);
		errors++;
		bad = 1'b1;
	endtask

	task automatic close_test(input string name);
		tests++;
		$display("%s: %s", name, bad ? "FAILED" : "ok");
		bad = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// sampled on the rising edge before the stimulus moves
	//////////////////////////////////////////////////////////////////////
	always @(posedge Clk) begin
		if (!rst_n) begin
			if (in_ready || done || cmd.req || !wr.src_rdy_n || !wr.sof_n || !wr.eof_n)
				reset_bad = 1'b1;
		end else if (!reset_seen) begin
			reset_seen = 1'b1;
			if (reset_bad)
				complain("outputs not idle during reset");
			close_test("reset state");
		end else begin
			if (start) begin
				foreach (offs[b]) begin
					offs[b] = 0;         // every block writes from the region bottom
					model[b].delete();
				end
				accepted = 0;
				bursts = 0;
				block_open = 1'b1;
			end
			if (in_valid && in_ready) begin
				model[bin_of(in_data[12:0])].push_back(in_data);
				accepted++;
			end
			if (in_ready && (busy || cmd.req))
				complain("stream accepting weights during a flush");

			// work out which bin a new command has to be for
			if (cmd.req && !prev_req) begin
				cur_bin = due_bin();
				busy = 1'b1;
				beat = 0;
				burst_len = (cur_bin < 0) ? 0 : model[cur_bin].size();
				if (cur_bin < 0)
					complain("write request with no bin due for a flush");
				else begin
					compare("cmd.addr", cmd.addr, DRAM_BASE + cur_bin * BIN_REGION_BYTES
						+ offs[cur_bin] * BYTES_PER_WORD);
					compare("cmd.len", 32'(cmd.len), burst_len * BYTES_PER_WORD);
				end
			end

			// source must stop presenting once every beat has gone
			if (busy && beat == burst_len && !wr.src_rdy_n)
				complain("src_rdy_n still low after the last beat");

			if (!wr.src_rdy_n && !resp.dst_rdy_n) begin
				if (!busy || cur_bin < 0 || model[cur_bin].size() == 0)
					complain("data beat with no weight left to send");
				else begin
					compare("wr.data", wr.data, model[cur_bin].pop_front());
					compare("wr.sof_n", wr.sof_n, beat != 0);
					compare("wr.eof_n", wr.eof_n, beat != burst_len - 1);
					offs[cur_bin]++;
					beat++;
				end
			end

			if (resp.cmplt && busy) begin
				busy = 1'b0;
				bursts++;
				if (beat != burst_len)
					complain($sformatf("burst ended after %0d of %0d beats", beat, burst_len));
				close_test($sformatf("burst %0d to bin %0d, %0d words", bursts, cur_bin, burst_len));
			end

			if (done) begin
				blocks++;
				if (!block_open)
					complain("done pulse without an open block");
				if (busy || accepted != BLOCK_LEN)
					complain("done before the block was written out");
				foreach (model[b])
					if (model[b].size() != 0)
						complain($sformatf("bin %0d not flushed at block end", b));
				compare("burst count", bursts, exp_bursts);
				block_open = 1'b0;
				close_test($sformatf("block %0d", blocks));
			end
			prev_req = cmd.req;
		end
	end

endmodule

// File: tests/weight_binning_tb.sv
/*
  testbench for the weight binning top level
  two blocks of weights from a table, plus a DRAM bus responder
  with late acknowledges and random back-pressure
*/
module weight_binning_tb;
	import binning_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int WAIT_LIMIT = 2000;   // cycles allowed for any one wait

	// two blocks of BLOCK_LEN, the key's bin noted per row
	localparam weight_t STIM [2*BLOCK_LEN] = '{
		32'h0100_0310, 32'h0200_E3F2, 32'h0300_1ABC, 32'h0400_0301,   // 3 3 7 3
		32'h0500_03FF, 32'h0600_0012, 32'h0700_1FFF, 32'h0800_0655,   // 3 0 7 5
		32'h0900_2345, 32'h0A00_1000, 32'h0B00_F234, 32'h0C00_0333,   // 3 7 7 3
		32'h0D00_0380, 32'h0E00_03C1, 32'h0F00_0155, 32'h1000_0800,   // 3 3 1 6
		32'h1100_00FF, 32'h1200_0700, 32'h1300_0BEE, 32'h1400_4100,   // 0 5 6 1
		32'h1500_0000, 32'h1600_0080, 32'h1700_0FFF, 32'h1800_0C3A,   // 0 0 6 6
		32'h2100_0400, 32'h2200_0200, 32'h2300_0399, 32'h2400_1800,   // 4 2 3 7
		32'h2500_05FF, 32'h2600_02AB, 32'h2700_0042, 32'h2800_8480,   // 4 2 0 4
		32'h2900_0511, 32'h2A00_0A00, 32'h2B00_0300, 32'h2C00_02FF,   // 4 6 3 2
		32'h2D00_A210, 32'h2E00_01EE, 32'h2F00_0600, 32'h3000_1234,   // 2 1 5 7
		32'h3100_0001, 32'h3200_0E01, 32'h3300_03AA, 32'h3400_03BB,   // 0 6 3 3
		32'h3500_07FE, 32'h3600_0101, 32'h3700_00AA, 32'h3800_1FFE    // 5 1 0 7
	};
	localparam int BLOCK_BURSTS [2] = '{7, 8};   // full-bin flushes plus end flushes

	logic        Clk;
	logic        rst_n;
	logic        start;
	logic        in_valid;
	weight_t     in_data;
	bus_resp_t   resp;
	logic        in_ready;
	logic        done;
	mst_cmd_t    cmd;
	mstwr_t      wr;
	int          exp_bursts;
	int          tests;
	int          errors;
	logic [31:0] rng = 32'hcdbf359b;

	initial begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	weight_binning_top weight_binning_top_inst (
		.Clk      (Clk),
		.rst_n    (rst_n),
		.start    (start),
		.in_valid (in_valid),
		.in_data  (in_data),
		.resp     (resp),
		.in_ready (in_ready),
		.done     (done),
		.cmd      (cmd),
		.wr       (wr)
	);

	dram_write_monitor monitor_inst (
		.Clk        (Clk),
		.rst_n      (rst_n),
		.start      (start),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_data    (in_data),
		.done       (done),
		.cmd        (cmd),
		.wr         (wr),
		.resp       (resp),
		.exp_bursts (exp_bursts),
		.tests      (tests),
		.errors     (errors)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// inputs change just after the rising edge
	task automatic next_cycle();
		@(posedge Clk);
		#1;
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$finish;
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus, one block per table half
	//////////////////////////////////////////////////////////////////////
	initial begin : stimulus
		int n;
		rst_n = 1'b0;
		start = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		exp_bursts = 0;
		repeat (RESET_CYCLES) @(posedge Clk);
		#1;
		rst_n = 1'b1;
		for (int blk = 0; blk < 2; blk++) begin
			next_cycle();
			next_cycle();                     // sequencer back in idle
			exp_bursts = BLOCK_BURSTS[blk];
			start = 1'b1;
			next_cycle();
			start = 1'b0;
			for (int i = 0; i < BLOCK_LEN; i++) begin
				in_valid = 1'b1;
				in_data = STIM[blk * BLOCK_LEN + i];
				n = 0;
				while (in_ready !== 1'b1) begin  // stalled while a bin drains
					next_cycle();
					n++;
					if (n > WAIT_LIMIT)
						abort_run("timeout: in_ready stayed low while a weight was waiting");
				end
				next_cycle();
			end
			in_valid = 1'b0;
			n = 0;
			while (done !== 1'b1) begin
				next_cycle();
				n++;
				if (n > WAIT_LIMIT)
					abort_run("timeout: no done pulse at the end of the block");
			end
		end
		next_cycle();
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0 && tests > 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// DRAM bus responder
	//////////////////////////////////////////////////////////////////////
	initial begin : bus_responder
		int   n;
		logic last;
		resp.cmdack = 1'b0;
		resp.cmplt = 1'b0;
		resp.dst_rdy_n = 1'b1;
		n = 0;
		while (rst_n !== 1'b1) begin
			next_cycle();
			n++;
			if (n > WAIT_LIMIT)
				abort_run("timeout: reset was never released");
		end
		forever begin
			n = 0;
			while (cmd.req !== 1'b1) begin
				next_cycle();
				n++;
				if (n > WAIT_LIMIT)
					abort_run("timeout: no write request from the DUT");
			end
			rng = xorshift32(rng);
			repeat (rng[1:0]) next_cycle();    // late acknowledge, 0 to 3 cycles
			resp.cmdack = 1'b1;
			next_cycle();
			resp.cmdack = 1'b0;
			n = 0;
			last = 1'b0;
			while (!last) begin
				rng = xorshift32(rng);
				resp.dst_rdy_n = (rng[9:8] == 2'b00);   // stall about one beat in four
				last = !wr.src_rdy_n && !resp.dst_rdy_n && !wr.eof_n;
				next_cycle();
				n++;
				if (n > WAIT_LIMIT)
					abort_run("timeout: burst never reached its last beat");
			end
			resp.dst_rdy_n = 1'b1;
			rng = xorshift32(rng);
			repeat (rng[1:0]) next_cycle();
			resp.cmplt = 1'b1;
			next_cycle();
			resp.cmplt = 1'b0;
		end
	end

endmodule

// File: files.f
design/binning_pkg.sv
design/bin_sequencer.sv
design/bin_buffer.sv
design/burst_writer.sv
design/weight_binning_top.sv
tests/dram_write_monitor.sv
tests/weight_binning_tb.sv

// File: Bender.yml
package:
  name: weight_binning

sources:
  - design/binning_pkg.sv
  - design/bin_sequencer.sv
  - design/bin_buffer.sv
  - design/burst_writer.sv
  - design/weight_binning_top.sv
  - target: test
    files:
      - tests/dram_write_monitor.sv
      - tests/weight_binning_tb.sv
